//--- Bender.yml
package:
  name: fm_mix

sources:
  - hw/fm_mix_pkg.sv
  - hw/slot_sequencer.sv
  - hw/channel_regs.sv
  - hw/mix_select.sv
  - hw/sat_acc.sv
  - hw/fm_mix_top.sv
  - target: simulation
    files:
      - bench/mix_checker.sv
      - bench/tb_fm_mix.sv

//--- bench/mix_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mix_checker (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               clk_en,
    input  logic                               cfg_we,
    input  logic [2:0]                         cfg_ch,
    input  fm_mix_pkg::chan_cfg_t              cfg_data,
    input  logic signed [fm_mix_pkg::OP_W-1:0] op_result,
    input  fm_mix_pkg::stereo_t                adpcm_a,
    input  fm_mix_pkg::stereo_t                adpcm_b,
    input  fm_mix_pkg::slot_t                  slot,
    input  fm_mix_pkg::stereo_t                snd,
    output int                                 errors,   // Running error count
    output int                                 frames    // Frame sums compared so far
);

    import fm_mix_pkg::*;

    localparam int SAT_MAX = 2 ** (SND_W - 1) - 1;
    localparam int SAT_MIN = -(2 ** (SND_W - 1));

    chan_cfg_t cfg_mirror [6]; // Host view of the six channels
    int        pos;            // Slot position in the frame, 0 to 23
    stereo_t   sums;           // Running frame sums
    stereo_t   exp_snd;        // Held output expected after a frame start
    logic      cmp_due;        // High for the cycle after an enabled frame start

    // Inner loop 0 1 2 4 5 6
    function automatic logic [2:0] seq_ch(input int p);
        int         k;
        logic [2:0] c;
        k = p % 6;
        c = k[2:0];
        if (k >= 3) begin
            c = c + 3'd1; // Skip channel 3
        end
        return c;
    endfunction

    function automatic logic [1:0] seq_op(input int p);
        int q;
        q = p / 6; // Outer loop
        return q[1:0];
    endfunction

    function automatic int mirror_idx(input logic [2:0] ch);
        return (ch < 3'd3) ? int'(ch) : int'(ch) - 1;
    endfunction

    function automatic slot_t expect_slot(input int p);
        slot_t      s;
        logic [1:0] op;
        op          = seq_op(p);
        s.cur_ch    = seq_ch(p);
        s.cur_op    = op;
        s.s1_enters = (op == 2'd0);
        s.s3_enters = (op == 2'd1); // Chip order s1 s3 s2 s4
        s.s2_enters = (op == 2'd2);
        s.s4_enters = (op == 2'd3);
        s.zero      = (p == 0);
        return s;
    endfunction

    function automatic logic signed [SND_W-1:0] clamp_add(input logic signed [SND_W-1:0] a,
                                                         input logic signed [SND_W-1:0] b);
        int s;
        s = int'(a) + int'(b);
        if (s > SAT_MAX) begin
            s = SAT_MAX;
        end else if (s < SAT_MIN) begin
            s = SAT_MIN;
        end
        return s[SND_W-1:0];
    endfunction

    // One slot of the frame sum, returns the next running sums
    function automatic stereo_t next_sums(input logic [2:0] ch, input logic [1:0] op,
                                          input chan_cfg_t cfg,
                                          input logic signed [OP_W-1:0] opr,
                                          input stereo_t a, input stereo_t b,
                                          input stereo_t acc, input logic first);
        stereo_t term;
        stereo_t res;
        logic    carrier;
        logic    en_l;
        logic    en_r;
        int      v_l;
        int      v_r;
        if (op == 2'd0 && ch == 3'd2) begin
            v_l  = 6 * int'($signed(a.l)); // ADPCM-A times six, kept to 16 bits
            v_r  = 6 * int'($signed(a.r));
            en_l = 1'b1;
            en_r = 1'b1;
        end else if (op == 2'd0 && ch == 3'd6) begin
            v_l  = int'($signed(b.l)) >>> 1; // ADPCM-B halved
            v_r  = int'($signed(b.r)) >>> 1;
            en_l = 1'b1;
            en_r = 1'b1;
        end else begin
            case (cfg.alg)
                3'd0, 3'd1, 3'd2, 3'd3: carrier = (op == 2'd3);          // s4 only
                3'd4:                   carrier = (op == 2'd2) || (op == 2'd3);
                3'd5, 3'd6:             carrier = (op != 2'd0);          // All but s1
                default:                carrier = 1'b1;
            endcase
            v_l  = int'(opr) >>> 1;
            v_r  = v_l;
            en_l = carrier && cfg.rl[1];
            en_r = carrier && cfg.rl[0];
        end
        term.l = v_l[SND_W-1:0];
        term.r = v_r[SND_W-1:0];
        if (first) begin
            res.l = en_l ? term.l : '0; // Restart at frame start
            res.r = en_r ? term.r : '0;
        end else begin
            res.l = en_l ? clamp_add(acc.l, term.l) : acc.l;
            res.r = en_r ? clamp_add(acc.r, term.r) : acc.r;
        end
        return res;
    endfunction

    initial begin
        errors = 0;
        frames = 0;
    end

    // Model state follows the same enabled edges as the DUT
    always @(posedge clk) begin
        if (reset) begin
            pos     <= 0;
            sums    <= '0;
            exp_snd <= '0;
            cmp_due <= 1'b0;
            for (int i = 0; i < 6; i++) begin
                cfg_mirror[i] <= '{alg: 3'd0, rl: 2'b11};
            end
        end else begin
            cmp_due <= 1'b0;
            if (clk_en) begin
                if (pos == 0) begin
                    exp_snd <= sums; // Finished frame goes out
                    cmp_due <= 1'b1;
                end
                sums <= next_sums(seq_ch(pos), seq_op(pos), cfg_mirror[mirror_idx(seq_ch(pos))],
                                  op_result, adpcm_a, adpcm_b, sums, pos == 0);
                pos  <= (pos == SLOTS_PER_FRAME - 1) ? 0 : pos + 1;
            end
            if (cfg_we && cfg_ch != 3'd3 && cfg_ch != 3'd7) begin
                cfg_mirror[mirror_idx(cfg_ch)] <= cfg_data; // Writes ignore clk_en
            end
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (slot !== expect_slot(pos)) begin
                $display("Mismatch at time %0t: slot expected %b got %b",
                         $time, expect_slot(pos), slot);
                errors = errors + 1;
            end
            if (cmp_due) begin
                frames = frames + 1;
                if (snd.l !== exp_snd.l) begin
                    $display("Mismatch at time %0t: snd.l expected %0d got %0d",
                             $time, $signed(exp_snd.l), $signed(snd.l));
                    errors = errors + 1;
                end
                if (snd.r !== exp_snd.r) begin
                    $display("Mismatch at time %0t: snd.r expected %0d got %0d",
                             $time, $signed(exp_snd.r), $signed(snd.r));
                    errors = errors + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_fm_mix.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fm_mix;

    import fm_mix_pkg::*;

    localparam int CLK_NS       = 4;
    localparam int TOTAL_FRAMES = 3 + 16 + 6 + 6 + 4 + 3; // Frames run by tests 1 to 6
    localparam int EN_SPACING   = 4;    // Worst-case cycles per enabled edge
    localparam int MARGIN_CYC   = 2000; // Reset, host writes, partial frames
    localparam int TIMEOUT_NS   =
        (TOTAL_FRAMES * SLOTS_PER_FRAME * EN_SPACING + MARGIN_CYC) * CLK_NS;

    logic                   clk;
    logic                   reset;
    logic                   clk_en;
    logic                   cfg_we;
    logic [2:0]             cfg_ch;
    chan_cfg_t              cfg_data;
    logic signed [OP_W-1:0] op_result;
    stereo_t                adpcm_a;
    stereo_t                adpcm_b;
    slot_t                  slot;
    stereo_t                snd;

    int                     errors;
    int                     frames;
    int                     en_pct;    // clk_en duty in percent
    int                     op_mode;   // 0 zero, 1 small random, 2 fixed
    logic signed [OP_W-1:0] op_fixed;
    stereo_t                a_val;     // ADPCM levels held on the ports
    stereo_t                b_val;
    int                     tests_run;
    int                     tests_failed;
    int                     err_mark;

    fm_mix_top dut_i (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .clk_en    ( clk_en    ),
        .cfg_we    ( cfg_we    ),
        .cfg_ch    ( cfg_ch    ),
        .cfg_data  ( cfg_data  ),
        .op_result ( op_result ),
        .adpcm_a   ( adpcm_a   ),
        .adpcm_b   ( adpcm_b   ),
        .slot      ( slot      ),
        .snd       ( snd       )
    );

    mix_checker chk_i (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .clk_en    ( clk_en    ),
        .cfg_we    ( cfg_we    ),
        .cfg_ch    ( cfg_ch    ),
        .cfg_data  ( cfg_data  ),
        .op_result ( op_result ),
        .adpcm_a   ( adpcm_a   ),
        .adpcm_b   ( adpcm_b   ),
        .slot      ( slot      ),
        .snd       ( snd       ),
        .errors    ( errors    ),
        .frames    ( frames    )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog: run did not finish within %0d ns, stopping", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

    // One clock of stimulus on the rising edge
    task automatic drive_inputs(input logic we, input logic [2:0] ch, input chan_cfg_t data);
        int v;
        @(posedge clk);
        v = int'($urandom_range(2000, 0)) - 1000;
        clk_en   <= ($urandom_range(99, 0) < en_pct);
        cfg_we   <= we;
        cfg_ch   <= ch;
        cfg_data <= data;
        case (op_mode)
            0:       op_result <= '0;
            1:       op_result <= v[OP_W-1:0];
            default: op_result <= op_fixed;
        endcase
        adpcm_a <= a_val;
        adpcm_b <= b_val;
    endtask

    task automatic idle_cycle();
        drive_inputs(1'b0, 3'd0, '0);
    endtask

    task automatic write_cfg(input logic [2:0] ch, input logic [2:0] alg, input logic [1:0] rl);
        chan_cfg_t d;
        d.alg = alg;
        d.rl  = rl;
        drive_inputs(1'b1, ch, d);
    endtask

    task automatic write_all(input logic [2:0] alg, input logic [1:0] rl);
        for (int ch = 0; ch < 7; ch++) begin
            if (ch != 3) begin
                write_cfg(ch[2:0], alg, rl);
            end
        end
    endtask

    // Waits until n more frame sums are compared
    task automatic run_frames(input int n);
        int target;
        target = frames + n;
        while (frames < target) begin
            idle_cycle();
        end
    endtask

    task automatic report_test(input int num, input string name);
        int n_err;
        n_err = errors - err_mark;
        tests_run++;
        if (n_err != 0) begin
            tests_failed++;
        end
        $display("[test %0d] %s: %s, %0d errors, %0d frames checked so far",
                 num, name, (n_err == 0) ? "pass" : "fail", n_err, frames);
        err_mark = errors;
    endtask

    initial begin
        int unsigned seed;
        int          r;
        logic [1:0]  rl_first [6];
        seed = 43;
        void'($urandom(seed)); // Seeded once
        rl_first = '{2'b11, 2'b10, 2'b01, 2'b00, 2'b10, 2'b01}; // Both, left, right, muted
        reset     = 1'b1;
        clk_en    = 1'b0;
        cfg_we    = 1'b0;
        cfg_ch    = '0;
        cfg_data  = '0;
        op_result = '0;
        adpcm_a   = '0;
        adpcm_b   = '0;
        en_pct    = 100;
        op_mode   = 0;
        op_fixed  = '0;
        a_val     = '0;
        b_val     = '0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // Test 1 slot walk with stalls
        en_pct  = 60;
        op_mode = 1;
        run_frames(3);
        report_test(1, "slot order");

        // Test 2 carrier set of each algorithm
        en_pct = 80;
        for (int alg = 0; alg < 8; alg++) begin
            write_all(alg[2:0], 2'b11);
            run_frames(2);
        end
        report_test(2, "algorithms");

        // Test 3 panning per channel
        for (int round = 0; round < 3; round++) begin
            for (int i = 0; i < 6; i++) begin
                r = (i < 3) ? i : i + 1; // Channel number
                if (round == 0) begin
                    write_cfg(r[2:0], 3'd7, rl_first[i]);
                end else begin
                    write_cfg(r[2:0], 3'($urandom_range(7, 0)), 2'($urandom_range(3, 0)));
                end
            end
            run_frames(2);
        end
        report_test(3, "panning");

        // Test 4 ADPCM slots alone
        op_mode = 0;
        for (int round = 0; round < 3; round++) begin
            r       = int'($urandom_range(5000, 0)) - 2500; // Sum stays below full scale
            a_val.l = r[SND_W-1:0];
            r       = int'($urandom_range(5000, 0)) - 2500;
            a_val.r = r[SND_W-1:0];
            r       = int'($urandom_range(65535, 0));
            b_val.l = r[SND_W-1:0];
            r       = int'($urandom_range(65535, 0));
            b_val.r = r[SND_W-1:0];
            run_frames(2);
        end
        report_test(4, "adpcm slots");

        // Test 5 full scale both ways
        write_all(3'd7, 2'b11);
        op_mode  = 2;
        op_fixed = {1'b0, {(OP_W-1){1'b1}}};
        a_val    = '{l: 16'sd5400, r: 16'sd5400};
        b_val    = '{l: 16'sh7FFF, r: 16'sh7FFF};
        run_frames(2);
        op_fixed = {1'b1, {(OP_W-1){1'b0}}};
        a_val    = '{l: -16'sd5400, r: -16'sd5400};
        b_val    = '{l: 16'sh8000, r: 16'sh8000};
        run_frames(2);
        report_test(5, "saturation");

        // Test 6 writes in mid-frame and to the unused channel numbers
        en_pct  = 70;
        op_mode = 1;
        a_val   = '0;
        b_val   = '0;
        write_all(3'd0, 2'b11);
        run_frames(1);
        while (slot.cur_op != 2'd1) begin
            idle_cycle();
        end
        write_cfg(3'd1, 3'd7, 2'b10);
        write_cfg(3'd4, 3'd5, 2'b01);
        write_cfg(3'd3, 3'd7, 2'b00); // No such channel
        write_cfg(3'd7, 3'd7, 2'b00);
        run_frames(2);
        report_test(6, "mid-frame writes");

        $display("Summary: %0d tests, %0d failed, %0d frames checked, %0d errors",
                 tests_run, tests_failed, frames, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hw/fm_mix_pkg.sv
hw/slot_sequencer.sv
hw/channel_regs.sv
hw/mix_select.sv
hw/sat_acc.sv
hw/fm_mix_top.sv
bench/mix_checker.sv
bench/tb_fm_mix.sv

//--- hw/channel_regs.sv
`timescale 1ns/1ps
`default_nettype none

module channel_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cfg_we,   // Host strobe, not tied to clk_en
    input  logic [2:0]            cfg_ch,
    input  fm_mix_pkg::chan_cfg_t cfg_data,
    input  logic [2:0]            cur_ch,
    output fm_mix_pkg::chan_cfg_t cur_cfg
);

    import fm_mix_pkg::*;

    chan_cfg_t  cfg_mem [NUM_CH]; // One entry per FM channel
    logic       cfg_valid;
    logic [2:0] wr_idx;
    logic [2:0] rd_idx;

    // Channel numbers 3 and 7 do not exist
    assign cfg_valid = (cfg_ch[1:0] != 2'b11);
    assign wr_idx    = ch_index(cfg_ch);
    assign rd_idx    = ch_index(cur_ch);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_CH; i++) begin
                cfg_mem[i] <= CFG_RESET;
            end
        end else if (cfg_we && cfg_valid) begin
            cfg_mem[wr_idx] <= cfg_data; // Seen by the mixer next cycle
        end
    end

    // Current channel entry, no latency
    assign cur_cfg = cfg_mem[rd_idx];

endmodule

`default_nettype wire

//--- hw/fm_mix_pkg.sv
`default_nettype none

package fm_mix_pkg;

    localparam int OP_W            = 14; // Operator result width
    localparam int SND_W           = 16; // Sample and accumulator width
    localparam int SLOTS_PER_FRAME = 24;
    localparam int NUM_CH          = SLOTS_PER_FRAME / 4; // Four operators per channel

    // ADPCM streams replace FM data on operator 0 of these channels
    localparam logic [2:0] ADPCM_A_CH = 3'd2;
    localparam logic [2:0] ADPCM_B_CH = 3'd6;

    typedef struct packed {
        logic [2:0] cur_ch;    // 0, 1, 2, 4, 5, 6
        logic [1:0] cur_op;    // Outer loop of the frame
        logic       s1_enters;
        logic       s2_enters;
        logic       s3_enters;
        logic       s4_enters;
        logic       zero;      // First slot of the frame
    } slot_t;

    typedef struct packed {
        logic [2:0] alg;
        logic [1:0] rl;        // Bit 1 left, bit 0 right
    } chan_cfg_t;

    typedef struct packed {
        logic signed [SND_W-1:0] l;
        logic signed [SND_W-1:0] r;
    } stereo_t;

    // Algorithm 0, both sides on
    localparam chan_cfg_t CFG_RESET = '{alg: 3'd0, rl: 2'b11};

    // Channel number to register index, 3 and 7 have no register
    function automatic logic [2:0] ch_index(input logic [2:0] ch);
        case (ch)
            3'd0:    ch_index = 3'd0;
            3'd1:    ch_index = 3'd1;
            3'd2:    ch_index = 3'd2;
            3'd4:    ch_index = 3'd3;
            3'd5:    ch_index = 3'd4;
            3'd6:    ch_index = 3'd5;
            default: ch_index = 3'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hw/fm_mix_top.sv
`timescale 1ns/1ps
`default_nettype none

module fm_mix_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               clk_en,    // Level, freezes everything when low
    input  logic                               cfg_we,
    input  logic [2:0]                         cfg_ch,
    input  fm_mix_pkg::chan_cfg_t              cfg_data,
    input  logic signed [fm_mix_pkg::OP_W-1:0] op_result, // Result of the slot shown now
    input  fm_mix_pkg::stereo_t                adpcm_a,
    input  fm_mix_pkg::stereo_t                adpcm_b,
    output fm_mix_pkg::slot_t                  slot,
    output fm_mix_pkg::stereo_t                snd
);

    import fm_mix_pkg::*;

    chan_cfg_t               cur_cfg;  // Config of the channel in slot
    stereo_t                 acc_in;
    logic                    acc_en_l;
    logic                    acc_en_r;
    logic signed [SND_W-1:0] snd_l;
    logic signed [SND_W-1:0] snd_r;

    slot_sequencer u_seq (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .clk_en ( clk_en ),
        .slot   ( slot   )
    );

    channel_regs u_regs (
        .clk      ( clk         ),
        .reset    ( reset       ),
        .cfg_we   ( cfg_we      ),
        .cfg_ch   ( cfg_ch      ),
        .cfg_data ( cfg_data    ),
        .cur_ch   ( slot.cur_ch ),
        .cur_cfg  ( cur_cfg     )
    );

    mix_select u_mix (
        .slot      ( slot      ),
        .cur_cfg   ( cur_cfg   ),
        .op_result ( op_result ),
        .adpcm_a   ( adpcm_a   ),
        .adpcm_b   ( adpcm_b   ),
        .acc_in    ( acc_in    ),
        .acc_en_l  ( acc_en_l  ),
        .acc_en_r  ( acc_en_r  )
    );

    // One accumulator per side
    sat_acc u_left (
        .clk    ( clk       ),
        .reset  ( reset     ),
        .clk_en ( clk_en    ),
        .zero   ( slot.zero ),
        .add_in ( acc_in.l  ),
        .add_en ( acc_en_l  ),
        .snd    ( snd_l     )
    );

    sat_acc u_right (
        .clk    ( clk       ),
        .reset  ( reset     ),
        .clk_en ( clk_en    ),
        .zero   ( slot.zero ),
        .add_in ( acc_in.r  ),
        .add_en ( acc_en_r  ),
        .snd    ( snd_r     )
    );

    assign snd = '{l: snd_l, r: snd_r};

endmodule

`default_nettype wire

//--- hw/mix_select.sv
`timescale 1ns/1ps
`default_nettype none

module mix_select (
    input  fm_mix_pkg::slot_t                  slot,
    input  fm_mix_pkg::chan_cfg_t              cur_cfg,
    input  logic signed [fm_mix_pkg::OP_W-1:0] op_result, // Result of the slot shown now
    input  fm_mix_pkg::stereo_t                adpcm_a,
    input  fm_mix_pkg::stereo_t                adpcm_b,
    output fm_mix_pkg::stereo_t                acc_in,
    output logic                               acc_en_l,
    output logic                               acc_en_r
);

    import fm_mix_pkg::*;

    logic                    carrier;    // Operator output goes to the mix
    logic                    is_adpcm_a;
    logic                    is_adpcm_b;
    logic signed [SND_W-1:0] op_ext;     // Sign extended to sample width
    logic signed [SND_W-1:0] op_half;
    stereo_t                 a_six;
    stereo_t                 b_half;

    // ADPCM takes operator 0 of its channel
    assign is_adpcm_a = slot.s1_enters && (slot.cur_ch == ADPCM_A_CH);
    assign is_adpcm_b = slot.s1_enters && (slot.cur_ch == ADPCM_B_CH);

    assign op_ext  = {{(SND_W-OP_W){op_result[OP_W-1]}}, op_result};
    assign op_half = op_ext >>> 1;

    // Four times plus two times
    assign a_six  = '{l: (adpcm_a.l <<< 2) + (adpcm_a.l <<< 1),
                      r: (adpcm_a.r <<< 2) + (adpcm_a.r <<< 1)};
    assign b_half = '{l: $signed(adpcm_b.l) >>> 1,
                      r: $signed(adpcm_b.r) >>> 1};

    // Carrier operators per algorithm
    always_comb begin
        case (cur_cfg.alg)
            3'd0, 3'd1, 3'd2, 3'd3: carrier = slot.s4_enters;
            3'd4:                   carrier = slot.s2_enters || slot.s4_enters;
            3'd5, 3'd6:             carrier = !slot.s1_enters; // All but s1
            default:                carrier = 1'b1;
        endcase
    end

    always_comb begin
        if (is_adpcm_a) begin
            acc_in   = a_six;
            acc_en_l = 1'b1; // ADPCM ignores panning
            acc_en_r = 1'b1;
        end else if (is_adpcm_b) begin
            acc_in   = b_half;
            acc_en_l = 1'b1;
            acc_en_r = 1'b1;
        end else begin
            acc_in.l = op_half;
            acc_in.r = op_half;
            acc_en_l = carrier && cur_cfg.rl[1]; // Left enable
            acc_en_r = carrier && cur_cfg.rl[0];
        end
    end

endmodule

`default_nettype wire

//--- hw/sat_acc.sv
`timescale 1ns/1ps
`default_nettype none

module sat_acc (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              clk_en,
    input  logic                              zero,    // Frame start slot
    input  logic signed [fm_mix_pkg::SND_W-1:0] add_in,
    input  logic                              add_en,
    output logic signed [fm_mix_pkg::SND_W-1:0] snd
);

    import fm_mix_pkg::*;

    localparam logic signed [SND_W-1:0] MAX_POS = {1'b0, {(SND_W-1){1'b1}}};
    localparam logic signed [SND_W-1:0] MAX_NEG = {1'b1, {(SND_W-1){1'b0}}};

    logic signed [SND_W-1:0] sum;     // Always held inside the 16-bit range
    logic signed [SND_W:0]   sum_ext; // One guard bit
    logic signed [SND_W-1:0] sum_sat;
    logic signed [SND_W-1:0] first;

    assign sum_ext = {sum[SND_W-1], sum} + {add_in[SND_W-1], add_in};

    // Clamp when the guard bit and the sign disagree
    always_comb begin
        if (sum_ext[SND_W] != sum_ext[SND_W-1]) begin
            sum_sat = sum_ext[SND_W] ? MAX_NEG : MAX_POS;
        end else begin
            sum_sat = sum_ext[SND_W-1:0];
        end
    end

    assign first = add_en ? add_in : '0; // Opening term of a new frame

    always_ff @(posedge clk) begin
        if (reset) begin
            sum <= '0;
            snd <= '0;
        end else if (clk_en) begin
            if (zero) begin
                snd <= sum;   // Finished frame
                sum <= first;
            end else if (add_en) begin
                sum <= sum_sat;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/slot_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module slot_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              clk_en,
    output fm_mix_pkg::slot_t slot
);

    logic [2:0] ch_cnt; // Inner loop, skips 3 and 7
    logic [1:0] op_cnt; // Outer loop
    logic       last_ch;
    logic       skip_ch;

    assign last_ch = (ch_cnt == 3'd6);
    assign skip_ch = (ch_cnt == 3'd2); // Next would be 3

    always_ff @(posedge clk) begin
        if (reset) begin
            ch_cnt <= 3'd0;
            op_cnt <= 2'd0;
        end else if (clk_en) begin
            if (last_ch) begin
                ch_cnt <= 3'd0;
                op_cnt <= op_cnt + 2'd1; // Wraps to a new frame after op 3
            end else if (skip_ch) begin
                ch_cnt <= 3'd4;
            end else begin
                ch_cnt <= ch_cnt + 3'd1;
            end
        end
    end

    // Slot flags decoded straight from the counters
    always_comb begin
        slot.cur_ch    = ch_cnt;
        slot.cur_op    = op_cnt;
        // Operator index to entry flag, chip order s1 s3 s2 s4
        slot.s1_enters = (op_cnt == 2'd0);
        slot.s3_enters = (op_cnt == 2'd1);
        slot.s2_enters = (op_cnt == 2'd2);
        slot.s4_enters = (op_cnt == 2'd3);
        slot.zero      = (op_cnt == 2'd0) && (ch_cnt == 3'd0); // Frame start
    end

endmodule

`default_nettype wire
